// ==== tb.f ====
design/exec_pkg.sv
design/exec_result_if.sv
design/exec_dispatch.sv
design/alu_unit.sv
design/mul_div_unit.sv
design/commit_stage.sv
design/exec_cluster.sv
tb/tb_exec_cluster.sv

// ==== Makefile ====
# Verilator flow for the execute cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Status comes from the search for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_exec_cluster.sv ====
`timescale 1ns/1ps
module tb_exec_cluster;

	localparam int n_corner_ops    = 18 * 25;   // Every code against every corner pair
	localparam int n_random_ops    = 400;
	localparam int op_count        = n_corner_ops + n_random_ops;
	localparam int drain_cycles    = 200;        // Longest divide plus stalls fits easily
	localparam int watchdog_cycles = op_count * 40 + drain_cycles + 200;

	localparam logic [3:0] alu_codes [10] = '{exec_pkg::alu_add, exec_pkg::alu_sub,
		exec_pkg::alu_sll, exec_pkg::alu_slt, exec_pkg::alu_sltu, exec_pkg::alu_xor,
		exec_pkg::alu_srl, exec_pkg::alu_sra, exec_pkg::alu_or, exec_pkg::alu_and};
	localparam logic [31:0] corners [5] = '{32'h0000_0000, 32'hffff_ffff,
		32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001};

	typedef struct packed {
		logic [exec_pkg::reg_addr_w-1:0] rd;
		logic                            we;
		logic [exec_pkg::xlen-1:0]       data;
	} commit_t;

	logic                            clk;
	logic                            rst;
	logic                            issue_valid;
	logic                            issue_ready;
	exec_pkg::exec_fn_u              issue_fn;
	logic [exec_pkg::reg_addr_w-1:0] issue_rd;
	logic                            issue_we;
	logic [exec_pkg::xlen-1:0]       issue_op_a, issue_op_b;
	logic                            commit_valid;
	logic                            commit_ready;
	logic [exec_pkg::reg_addr_w-1:0] commit_rd;
	logic                            commit_we;
	logic [exec_pkg::xlen-1:0]       commit_data;

	commit_t     exp_q [$];      // Expected commits with the oldest first
	commit_t     head;           // Queue head as seen before this edge
	logic        head_valid;
	logic [31:0] rng = 32'd34;
	logic [31:0] stall_rng = 32'd34;
	int          errors = 0;
	int          issued = 0;
	int          commits = 0;

	exec_cluster exec_cluster_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One in eight operands is a corner value
	function automatic logic [31:0] rand_operand();
		rng = xorshift32(rng);
		if (rng[2:0] == 3'd0)
			return corners[rng[10:8] % 5];
		return xorshift32(rng ^ 32'h5a5a_1234);
	endfunction

	function automatic logic [4:0] pick_rd();
		rng = xorshift32(rng);
		return (rng[2:0] == 3'd0) ? 5'd0 : rng[9:5];   // x0 fairly often
	endfunction

	function automatic exec_pkg::exec_fn_u alu_fn(input logic [3:0] code);
		exec_pkg::exec_fn_u f;
		f = '0;
		f.alu.op = code;   // Unit bit stays 0
		return f;
	endfunction

	function automatic exec_pkg::exec_fn_u md_fn(input logic [2:0] code);
		exec_pkg::exec_fn_u f;
		f = '0;
		f.md.unit = 1'b1;
		f.md.op   = code;
		return f;
	endfunction

	// RV32I and RV32M reference with products taken mod 2^64 on extended operands
	function automatic logic [31:0] expected_data(input exec_pkg::exec_fn_u f,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0]        p_uu, p_ss, p_su, sra_ext;
		logic signed [31:0] sa, sb;
		logic               ovf;
		p_uu    = {32'd0, a} * {32'd0, b};
		p_ss    = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		p_su    = {{32{a[31]}}, a} * {32'd0, b};
		sra_ext = {{32{a[31]}}, a} >> b[4:0];
		sa      = a;
		sb      = b;
		ovf     = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		if (!f.alu.unit) begin
			case (f.alu.op)
				exec_pkg::alu_add:  return a + b;
				exec_pkg::alu_sub:  return a - b;
				exec_pkg::alu_sll:  return a << b[4:0];
				exec_pkg::alu_slt:  return {31'd0, sa < sb};
				exec_pkg::alu_sltu: return {31'd0, a < b};
				exec_pkg::alu_xor:  return a ^ b;
				exec_pkg::alu_srl:  return a >> b[4:0];
				exec_pkg::alu_sra:  return sra_ext[31:0];
				exec_pkg::alu_or:   return a | b;
				default:            return a & b;
			endcase
		end
		case (f.md.op)
			exec_pkg::md_mul:    return p_uu[31:0];
			exec_pkg::md_mulh:   return p_ss[63:32];
			exec_pkg::md_mulhsu: return p_su[63:32];
			exec_pkg::md_mulhu:  return p_uu[63:32];
			exec_pkg::md_div: begin
				if (b == 32'd0) return 32'hffff_ffff;
				else if (ovf) return a;
				else return sa / sb;   // Truncates toward zero
			end
			exec_pkg::md_divu: begin
				if (b == 32'd0) return 32'hffff_ffff;
				else return a / b;
			end
			exec_pkg::md_rem: begin
				if (b == 32'd0) return a;
				else if (ovf) return 32'd0;
				else return sa % sb;   // Sign of dividend
			end
			default: begin
				if (b == 32'd0) return a;
				else return a % b;
			end
		endcase
	endfunction

	// Hold the op until the DUT takes it
	task automatic issue_op(input exec_pkg::exec_fn_u f, input logic [4:0] rd,
		input logic we, input logic [31:0] a, input logic [31:0] b);
		issue_valid <= 1'b1;
		issue_fn    <= f;
		issue_rd    <= rd;
		issue_we    <= we;
		issue_op_a  <= a;
		issue_op_b  <= b;
		@(posedge clk);
		while (!issue_ready) @(posedge clk);
		issue_valid <= 1'b0;
	endtask

	// Random back-pressure that is low a quarter of the time
	always @(posedge clk) begin
		stall_rng = xorshift32(stall_rng);
		commit_ready <= !rst && (stall_rng[1:0] != 2'b00);
	end

	// Order queue
	always @(posedge clk) begin
		if (!rst && issue_valid && issue_ready) begin
			exp_q.push_back(commit_t'{issue_rd, issue_we && (issue_rd != '0),
				expected_data(issue_fn, issue_op_a, issue_op_b)});
			issued++;
		end
		if (!rst && commit_valid && commit_ready) begin
			commits++;   // Every transfer, stray ones included
			if (exp_q.size() > 0)
				void'(exp_q.pop_front());
		end
		head_valid <= (exp_q.size() != 0);
		if (exp_q.size() != 0) head <= exp_q[0];
	end

	a_known: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready |-> head_valid)
	else begin
		errors++;
		$display("Error: commit transfer with no operation outstanding");
	end
	a_rd: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready && head_valid |-> commit_rd == head.rd)
	else begin
		errors++;
		$display("Error: commit_rd expected %h got %h", $sampled(head.rd), $sampled(commit_rd));
	end
	a_we: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready && head_valid |-> commit_we == head.we)
	else begin
		errors++;
		$display("Error: commit_we expected %h got %h", $sampled(head.we), $sampled(commit_we));
	end
	a_data: assert property (@(posedge clk) disable iff (rst)
		commit_valid && commit_ready && head_valid |-> commit_data == head.data)
	else begin
		errors++;
		$display("Error: commit_data expected %h got %h", $sampled(head.data),
			$sampled(commit_data));
	end
	a_hold: assert property (@(posedge clk) disable iff (rst)
		commit_valid && !commit_ready |=> commit_valid && $stable(commit_rd)
		&& $stable(commit_we) && $stable(commit_data))
	else begin
		errors++;
		$display("Error: commit output changed while stalled, commit_rd %h commit_data %h",
			$sampled(commit_rd), $sampled(commit_data));
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: run still busy after %0d cycles, %0d errors so far",
			watchdog_cycles, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		exec_pkg::exec_fn_u f;
		int                 c;
		int                 i;
		int                 j;
		rst          = 1'b1;
		issue_valid  = 1'b0;
		issue_fn     = '0;
		issue_rd     = '0;
		issue_we     = 1'b0;
		issue_op_a   = '0;
		issue_op_b   = '0;
		commit_ready = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		a_rst_valid: assert (commit_valid === 1'b0) else begin
			errors++;
			$display("Error: commit_valid after reset expected 0 got %h", commit_valid);
		end
		a_rst_ready: assert (issue_ready === 1'b1) else begin
			errors++;
			$display("Error: issue_ready after reset expected 1 got %h", issue_ready);
		end
		@(posedge clk);
		// Corner pairs for every code
		for (c = 0; c < 18; c++) begin
			for (i = 0; i < 5; i++) begin
				for (j = 0; j < 5; j++) begin
					f = (c < 10) ? alu_fn(alu_codes[c]) : md_fn(3'(c - 10));
					issue_op(f, pick_rd(), rng[11], corners[i], corners[j]);
				end
			end
		end
		// Random mix with gaps
		for (i = 0; i < n_random_ops; i++) begin
			rng = xorshift32(rng);
			c = rng[7:4] % 10;
			f = rng[0] ? md_fn(rng[3:1]) : alu_fn(alu_codes[c]);
			issue_op(f, pick_rd(), rng[12], rand_operand(), rand_operand());
			rng = xorshift32(rng);
			if (rng[1:0] == 2'b00)
				repeat (rng[3:2]) @(posedge clk);
		end
		// Bounded wait for the last results
		for (i = 0; i < drain_cycles && exp_q.size() != 0; i++)
			@(posedge clk);
		repeat (8) @(posedge clk);   // Catch stray commits
		a_drained: assert (exp_q.size() == 0 && issued == commits) else begin
			errors++;
			$display("Error: %0d operations issued but %0d committed and %0d left queued",
				issued, commits, exp_q.size());
		end
		$display("Summary: %0d issued, %0d committed, %0d errors", issued, commits, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== design/exec_cluster.sv ====
`timescale 1ns/1ps
module exec_cluster (
	input  logic                            clk,
	input  logic                            rst,
	// Issue side
	input  logic                            issue_valid,
	output logic                            issue_ready,
	input  exec_pkg::exec_fn_u              issue_fn,
	input  logic [exec_pkg::reg_addr_w-1:0] issue_rd,
	input  logic                            issue_we,
	input  logic [exec_pkg::xlen-1:0]       issue_op_a,
	input  logic [exec_pkg::xlen-1:0]       issue_op_b,
	// Writeback side
	output logic                            commit_valid,
	input  logic                            commit_ready,
	output logic [exec_pkg::reg_addr_w-1:0] commit_rd,
	output logic                            commit_we,
	output logic [exec_pkg::xlen-1:0]       commit_data
);

	logic                            alu_go, md_go;
	logic                            alu_free, md_busy;
	exec_pkg::exec_fn_u              disp_fn;
	logic [exec_pkg::reg_addr_w-1:0] disp_rd;
	logic                            disp_we;
	logic [exec_pkg::xlen-1:0]       disp_op_a, disp_op_b;

	exec_result_if alu_res ();   // ALU to commit
	exec_result_if md_res ();    // Mul/div to commit

	exec_dispatch dispatch (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_fn    (issue_fn),
		.issue_rd    (issue_rd),
		.issue_we    (issue_we),
		.issue_op_a  (issue_op_a),
		.issue_op_b  (issue_op_b),
		.alu_free    (alu_free),
		.md_busy     (md_busy),
		.alu_go      (alu_go),
		.md_go       (md_go),
		.fn          (disp_fn),
		.rd          (disp_rd),
		.we          (disp_we),
		.op_a        (disp_op_a),
		.op_b        (disp_op_b)
	);

	alu_unit alu (
		.clk      (clk),
		.rst      (rst),
		.go       (alu_go),
		.fn       (disp_fn),
		.rd       (disp_rd),
		.we       (disp_we),
		.op_a     (disp_op_a),
		.op_b     (disp_op_b),
		.alu_free (alu_free),
		.res      (alu_res.unit)
	);

	mul_div_unit mul_div (
		.clk  (clk),
		.rst  (rst),
		.go   (md_go),
		.fn   (disp_fn),
		.rd   (disp_rd),
		.we   (disp_we),
		.op_a (disp_op_a),
		.op_b (disp_op_b),
		.busy (md_busy),
		.res  (md_res.unit)
	);

	commit_stage commit (
		.clk          (clk),
		.rst          (rst),
		.alu_res      (alu_res.commit),
		.md_res       (md_res.commit),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready),
		.commit_rd    (commit_rd),
		.commit_we    (commit_we),
		.commit_data  (commit_data)
	);

endmodule

// ==== design/commit_stage.sv ====
`timescale 1ns/1ps
module commit_stage (
	input  logic                            clk,
	input  logic                            rst,
	exec_result_if.commit                   alu_res,
	exec_result_if.commit                   md_res,
	output logic                            commit_valid,
	input  logic                            commit_ready,
	output logic [exec_pkg::reg_addr_w-1:0] commit_rd,
	output logic                            commit_we,
	output logic [exec_pkg::xlen-1:0]       commit_data
);

	logic                            load;      // Output reg empty or draining
	logic                            pick_alu;  // ALU stream wins
	logic [exec_pkg::reg_addr_w-1:0] nxt_rd;
	logic                            nxt_we;
	logic [exec_pkg::xlen-1:0]       nxt_data;

	assign load = !commit_valid || commit_ready;

	// Any ALU result pending is older than the single mul/div op
	assign pick_alu = alu_res.valid;

	assign alu_res.ready = load;
	assign md_res.ready  = load && !alu_res.valid;

	always_comb begin
		if (pick_alu) begin
			nxt_rd   = alu_res.rd;
			nxt_we   = alu_res.we;
			nxt_data = alu_res.data;
		end else begin
			nxt_rd   = md_res.rd;
			nxt_we   = md_res.we;
			nxt_data = md_res.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid <= 1'b0;
		end else if (load) begin
			commit_valid <= alu_res.valid || md_res.valid;
		end
	end

	// Holds while stalled
	always_ff @(posedge clk) begin
		if (load) begin
			commit_rd   <= nxt_rd;
			commit_we   <= nxt_we && (nxt_rd != '0);   // x0 stays zero
			commit_data <= nxt_data;
		end
	end

endmodule

// ==== design/mul_div_unit.sv ====
`timescale 1ns/1ps
module mul_div_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            go,
	input  exec_pkg::exec_fn_u              fn,
	input  logic [exec_pkg::reg_addr_w-1:0] rd,
	input  logic                            we,
	input  logic [exec_pkg::xlen-1:0]       op_a,
	input  logic [exec_pkg::xlen-1:0]       op_b,
	output logic                            busy,   // High until result is taken
	exec_result_if.unit                     res
);

	localparam int msb = exec_pkg::xlen - 1;

	logic [2:0]                  op_q;       // Latched funct3
	logic                        mul_pend;   // Product held, pick half next
	logic                        div_run;    // Restoring loop running
	logic                        div_fin;    // Sign fixup next
	logic [4:0]                  count;      // Divide step
	logic a_sx, b_sx, div_signed;
	logic signed [2*exec_pkg::xlen+1:0] prod_full;
	logic [2*exec_pkg::xlen-1:0] prod;
	logic [msb:0]                a_mag, b_mag;
	logic [msb:0]                quo, rem, dvsr;
	logic [exec_pkg::xlen:0]     rem_sh, diff;
	logic                        q_neg, r_neg;
	logic [msb:0]                q_fix, r_fix;

	always_comb begin
		a_sx = (fn.md.op == exec_pkg::md_mulh) || (fn.md.op == exec_pkg::md_mulhsu);
		b_sx = (fn.md.op == exec_pkg::md_mulh);
		// 33x33 signed covers all four multiply flavours
		prod_full = $signed({a_sx & op_a[msb], op_a}) * $signed({b_sx & op_b[msb], op_b});
		div_signed = !fn.md.op[0];   // DIV and REM
		a_mag = (div_signed && op_a[msb]) ? -op_a : op_a;
		b_mag = (div_signed && op_b[msb]) ? -op_b : op_b;
		rem_sh = {rem, quo[msb]};       // Shift next dividend bit in
		diff   = rem_sh - {1'b0, dvsr};
		q_fix  = q_neg ? -quo : quo;
		r_fix  = r_neg ? -rem : rem;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			mul_pend  <= 1'b0;
			div_run   <= 1'b0;
			div_fin   <= 1'b0;
			count     <= '0;
			res.valid <= 1'b0;
		end else begin
			mul_pend <= go && !fn.md.op[2];
			div_fin  <= div_run && (count == '1);   // 32nd step just done
			if (go) begin
				div_run <= fn.md.op[2];
				count   <= '0;
			end else if (div_run) begin
				count <= count + 5'd1;
				if (count == '1)
					div_run <= 1'b0;
			end
			if (go)
				busy <= 1'b1;
			else if (res.valid && res.ready)
				busy <= 1'b0;
			if (mul_pend || div_fin)
				res.valid <= 1'b1;
			else if (res.ready)
				res.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			op_q   <= fn.md.op;
			res.rd <= rd;
			res.we <= we;
			prod   <= prod_full[2*exec_pkg::xlen-1:0];
			quo    <= a_mag;
			rem    <= '0;
			dvsr   <= b_mag;
			// Divide by zero keeps quotient all ones
			q_neg  <= div_signed && (op_a[msb] ^ op_b[msb]) && (op_b != '0);
			r_neg  <= div_signed && op_a[msb];   // Remainder takes dividend sign
		end
		if (div_run) begin
			if (!diff[exec_pkg::xlen]) begin   // Fits, subtract
				rem <= diff[msb:0];
				quo <= {quo[msb-1:0], 1'b1};
			end else begin
				rem <= rem_sh[msb:0];
				quo <= {quo[msb-1:0], 1'b0};
			end
		end
		if (mul_pend)
			res.data <= (op_q == exec_pkg::md_mul) ? prod[msb:0] : prod[2*exec_pkg::xlen-1:exec_pkg::xlen];
		// Overflow case falls out of the magnitudes, 0x80000000 rem 0
		if (div_fin)
			res.data <= op_q[1] ? r_fix : q_fix;
	end

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps
module alu_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            go,
	input  exec_pkg::exec_fn_u              fn,
	input  logic [exec_pkg::reg_addr_w-1:0] rd,
	input  logic                            we,
	input  logic [exec_pkg::xlen-1:0]       op_a,
	input  logic [exec_pkg::xlen-1:0]       op_b,
	output logic                            alu_free,
	exec_result_if.unit                     res
);

	logic [exec_pkg::xlen-1:0] result;
	logic [4:0]                shamt;

	assign shamt = op_b[4:0];   // RV32 uses low five bits only

	// Empty, or draining into commit this cycle
	assign alu_free = !res.valid || res.ready;

	always_comb begin
		case (fn.alu.op)
			exec_pkg::alu_add:  result = op_a + op_b;
			exec_pkg::alu_sub:  result = op_a - op_b;
			exec_pkg::alu_sll:  result = op_a << shamt;
			exec_pkg::alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
			exec_pkg::alu_sltu: result = {31'd0, op_a < op_b};
			exec_pkg::alu_xor:  result = op_a ^ op_b;
			exec_pkg::alu_srl:  result = op_a >> shamt;
			exec_pkg::alu_sra:  result = $signed(op_a) >>> shamt;   // Sign fills in
			exec_pkg::alu_or:   result = op_a | op_b;
			exec_pkg::alu_and:  result = op_a & op_b;
			default:            result = op_a + op_b;   // Unused codes act as add
		endcase
	end

	// Result valid flag
	always_ff @(posedge clk) begin
		if (rst) begin
			res.valid <= 1'b0;
		end else if (alu_free) begin
			res.valid <= go;   // Refill or go empty
		end
	end

	// One held result
	always_ff @(posedge clk) begin
		if (alu_free && go) begin
			res.data <= result;
			res.rd   <= rd;
			res.we   <= we;
		end
	end

endmodule

// ==== design/exec_dispatch.sv ====
`timescale 1ns/1ps
module exec_dispatch (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            issue_valid,
	output logic                            issue_ready,
	input  exec_pkg::exec_fn_u              issue_fn,
	input  logic [exec_pkg::reg_addr_w-1:0] issue_rd,
	input  logic                            issue_we,
	input  logic [exec_pkg::xlen-1:0]       issue_op_a,
	input  logic [exec_pkg::xlen-1:0]       issue_op_b,
	input  logic                            alu_free,   // ALU result reg can load
	input  logic                            md_busy,    // Mul/div holds an op
	output logic                            alu_go,
	output logic                            md_go,
	output exec_pkg::exec_fn_u              fn,
	output logic [exec_pkg::reg_addr_w-1:0] rd,
	output logic                            we,
	output logic [exec_pkg::xlen-1:0]       op_a,
	output logic [exec_pkg::xlen-1:0]       op_b
);

	logic md_guard;   // Mul/div started last cycle
	logic to_md;      // Unit select of the offered op
	logic take;       // Issue transfer this cycle

	assign to_md = issue_fn.alu.unit;

	// Nothing passes an in-flight mul/div, so commit order stays program order
	// ALU ops also need a free result slot
	assign issue_ready = !md_busy && !md_guard && (to_md || alu_free);
	assign take        = issue_valid && issue_ready;

	assign alu_go = take && !to_md;
	assign md_go  = take && to_md;

	// Payload goes straight on, both units register it
	assign fn   = issue_fn;
	assign rd   = issue_rd;
	assign we   = issue_we;
	assign op_a = issue_op_a;
	assign op_b = issue_op_b;

	// Covers the cycle after md_go in case busy lags by one
	always_ff @(posedge clk) begin
		if (rst) begin
			md_guard <= 1'b0;
		end else begin
			md_guard <= md_go;
		end
	end

endmodule

// ==== design/exec_result_if.sv ====
`timescale 1ns/1ps
interface exec_result_if;

	logic                            valid;
	logic                            ready;   // From commit
	logic [exec_pkg::reg_addr_w-1:0] rd;
	logic                            we;
	logic [exec_pkg::xlen-1:0]       data;

	// Producer side, one per execute unit
	modport unit (
		output valid, rd, we, data,
		input  ready
	);

	// Consumer side
	modport commit (
		input  valid, rd, we, data,
		output ready
	);

endinterface

// ==== design/exec_pkg.sv ====
package exec_pkg;

	// Datapath and register file widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// ALU codes, {instr[30], funct3}
	localparam logic [3:0] alu_add  = 4'b0000;
	localparam logic [3:0] alu_sub  = 4'b1000;
	localparam logic [3:0] alu_sll  = 4'b0001;
	localparam logic [3:0] alu_slt  = 4'b0010;
	localparam logic [3:0] alu_sltu = 4'b0011;
	localparam logic [3:0] alu_xor  = 4'b0100;
	localparam logic [3:0] alu_srl  = 4'b0101;
	localparam logic [3:0] alu_sra  = 4'b1101;
	localparam logic [3:0] alu_or   = 4'b0110;
	localparam logic [3:0] alu_and  = 4'b0111;

	// RV32M funct3
	localparam logic [2:0] md_mul    = 3'b000;
	localparam logic [2:0] md_mulh   = 3'b001;
	localparam logic [2:0] md_mulhsu = 3'b010;
	localparam logic [2:0] md_mulhu  = 3'b011;
	localparam logic [2:0] md_div    = 3'b100;
	localparam logic [2:0] md_divu   = 3'b101;
	localparam logic [2:0] md_rem    = 3'b110;
	localparam logic [2:0] md_remu   = 3'b111;

	// Function word, top bit picks the unit
	typedef union packed {
		struct packed {
			logic       unit;   // 0 for ALU
			logic [3:0] op;     // ALU code
		} alu;
		struct packed {
			logic       unit;   // 1 for mul/div
			logic       spare;  // Not decoded
			logic [2:0] op;     // RV32M funct3
		} md;
	} exec_fn_u;

endpackage
